/* hdl/mem_1r1u_pkg.sv */
package mem_1r1u_pkg;

  localparam int DATA_W     = 16;
  localparam int NUM_BANKS  = 4;
  localparam int BANK_W     = 2;
  localparam int NUM_ROWS   = 16;
  localparam int ROW_W      = 4;
  localparam int ADDR_W     = ROW_W + BANK_W;
  localparam int SRAM_DELAY = 2;

  typedef logic [DATA_W-1:0] word_t;

  // Bank in the low bits, so consecutive addresses hit different banks.
  typedef struct packed {
    logic [ROW_W-1:0]  row;
    logic [BANK_W-1:0] bank;
  } vaddr_fld_t;

  typedef union packed {
    logic [ADDR_W-1:0] flat;
    vaddr_fld_t        fld;
  } vaddr_u;

  typedef struct packed {
    logic   valid;
    vaddr_u addr;
  } rd_req_t;

  typedef struct packed {
    logic  valid;
    word_t data;
  } upd_req_t;

  typedef struct packed {
    logic  valid;
    word_t data;
  } rd_rsp_t;

  typedef struct packed {
    logic             rd;
    logic             wr;
    logic [ROW_W-1:0] row;
    word_t            wdata;
  } bank_req_t;

  // Which bank's word the cache row currently holds.
  typedef struct packed {
    logic              valid;
    logic [BANK_W-1:0] bank;
  } map_ent_t;

  typedef struct packed {
    logic             en;
    logic [ROW_W-1:0] row;
    map_ent_t         ent;
  } map_wr_t;

  typedef struct packed {
    logic             en;
    logic [ROW_W-1:0] row;
    word_t            data;
  } cache_wr_t;

  // Word committed to a home bank, either an update or an eviction.
  typedef struct packed {
    logic   en;
    vaddr_u addr;
    word_t  data;
  } upd_wr_t;

  typedef struct packed {
    logic     vld;
    map_ent_t ent;
  } fwd_map_t;

  typedef struct packed {
    logic  vld;
    word_t data;
  } fwd_word_t;

  typedef struct packed {
    logic      valid;
    vaddr_u    addr;
    fwd_map_t  map;
    fwd_word_t cache;
    fwd_word_t data;
  } pipe_out_t;

endpackage

/* hdl/dp_sram.sv */
module dp_sram #(
  parameter int WIDTH = mem_1r1u_pkg::DATA_W
) (
  input  logic                           clk,
  input  logic                           wr_en,
  input  logic [mem_1r1u_pkg::ROW_W-1:0] wr_row,
  input  logic [WIDTH-1:0]               wr_data,
  input  logic [mem_1r1u_pkg::ROW_W-1:0] rd_row,
  output logic [WIDTH-1:0]               rd_data
);
  import mem_1r1u_pkg::*;

  logic [WIDTH-1:0] mem [NUM_ROWS];
  logic [WIDTH-1:0] rd_q [SRAM_DELAY];

  // Read sees the array before this cycle's write.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_row] <= wr_data;
    end
    rd_q[0] <= mem[rd_row];
    for (int i = 1; i < SRAM_DELAY; i++) begin
      rd_q[i] <= rd_q[i-1];
    end
  end

  assign rd_data = rd_q[SRAM_DELAY-1];

endmodule

/* hdl/bank_array.sv */
module bank_array (
  input  logic                                                 clk,
  input  mem_1r1u_pkg::bank_req_t [mem_1r1u_pkg::NUM_BANKS-1:0] bank_req,
  output mem_1r1u_pkg::word_t [mem_1r1u_pkg::NUM_BANKS-1:0]     bank_dout
);
  import mem_1r1u_pkg::*;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    word_t mem [NUM_ROWS];
    word_t rd_q [SRAM_DELAY];

    // Single port, so a write takes the cycle.
    always_ff @(posedge clk) begin
      if (bank_req[b].wr) begin
        mem[bank_req[b].row] <= bank_req[b].wdata;
      end else if (bank_req[b].rd) begin
        rd_q[0] <= mem[bank_req[b].row];
      end
      for (int i = 1; i < SRAM_DELAY; i++) begin
        rd_q[i] <= rd_q[i-1];
      end
    end

    assign bank_dout[b] = rd_q[SRAM_DELAY-1];
  end

endmodule

/* hdl/rd_fwd_pipe.sv */
module rd_fwd_pipe (
  input  logic                    clk,
  input  logic                    rstvld,
  input  mem_1r1u_pkg::rd_req_t   rd_acc,
  input  mem_1r1u_pkg::map_wr_t   map_wr,
  input  mem_1r1u_pkg::cache_wr_t cache_wr,
  input  mem_1r1u_pkg::upd_wr_t   upd_wr,
  output mem_1r1u_pkg::pipe_out_t pipe
);
  import mem_1r1u_pkg::*;

  pipe_out_t stage [SRAM_DELAY];

  // Newest map write to the read's row.
  function automatic fwd_map_t map_step(fwd_map_t prev, logic [ROW_W-1:0] row,
                                        map_wr_t mw);
    fwd_map_t nxt;
    nxt = prev;
    if (mw.en && mw.row == row) begin
      nxt.vld = 1'b1;
      nxt.ent = mw.ent;
    end
    return nxt;
  endfunction

  function automatic fwd_word_t cache_step(fwd_word_t prev, logic [ROW_W-1:0] row,
                                           cache_wr_t cw);
    fwd_word_t nxt;
    nxt = prev;
    if (cw.en && cw.row == row) begin
      nxt.vld = 1'b1;
      nxt.data = cw.data;
    end
    return nxt;
  endfunction

  // Newest value of the address itself, in a bank or in the cache.
  function automatic fwd_word_t data_step(fwd_word_t prev, vaddr_u addr, upd_wr_t uw,
                                          map_wr_t mw, cache_wr_t cw);
    fwd_word_t nxt;
    nxt = prev;
    if (uw.en && uw.addr.flat == addr.flat) begin
      nxt.vld = 1'b1;
      nxt.data = uw.data;
    end else if (cw.en && mw.en && mw.ent.valid && cw.row == addr.fld.row &&
                 mw.ent.bank == addr.fld.bank) begin
      nxt.vld = 1'b1;
      nxt.data = cw.data;
    end
    return nxt;
  endfunction

  for (genvar i = 0; i < SRAM_DELAY; i++) begin : g_stage
    pipe_out_t prev;
    pipe_out_t nxt;

    if (i == 0) begin : g_first
      always_comb begin
        prev = '0;
        prev.valid = rd_acc.valid;
        prev.addr = rd_acc.addr;
      end
    end else begin : g_later
      assign prev = stage[i-1];
    end

    always_comb begin
      nxt = prev;
      nxt.map = map_step(prev.map, prev.addr.fld.row, map_wr);
      nxt.cache = cache_step(prev.cache, prev.addr.fld.row, cache_wr);
      nxt.data = data_step(prev.data, prev.addr, upd_wr, map_wr, cache_wr);
    end

    always_ff @(posedge clk) begin
      if (rstvld) begin
        stage[i].valid <= 1'b0;
        stage[i].map.vld <= 1'b0;
        stage[i].cache.vld <= 1'b0;
        stage[i].data.vld <= 1'b0;
      end else begin
        stage[i] <= nxt;
      end
    end
  end

  assign pipe = stage[SRAM_DELAY-1];

endmodule

/* hdl/core_ctrl.sv */
module core_ctrl (
  input  logic                                                 clk,
  input  logic                                                 rstvld,
  input  mem_1r1u_pkg::rd_req_t                                rd,
  input  mem_1r1u_pkg::upd_req_t                               upd,
  output mem_1r1u_pkg::rd_rsp_t                                rsp,
  output logic                                                 ready,
  output mem_1r1u_pkg::bank_req_t [mem_1r1u_pkg::NUM_BANKS-1:0] bank_req,
  input  mem_1r1u_pkg::word_t [mem_1r1u_pkg::NUM_BANKS-1:0]     bank_dout,
  output mem_1r1u_pkg::map_wr_t                                map_wr,
  output mem_1r1u_pkg::cache_wr_t                              cache_wr,
  output logic [mem_1r1u_pkg::ROW_W-1:0]                       cache_rd_row,
  input  mem_1r1u_pkg::map_ent_t                               map_dout,
  input  mem_1r1u_pkg::word_t                                  cache_dout,
  output mem_1r1u_pkg::rd_req_t                                rd_acc,
  output mem_1r1u_pkg::upd_wr_t                                upd_wr,
  input  mem_1r1u_pkg::pipe_out_t                              pipe
);
  import mem_1r1u_pkg::*;

  logic              init_busy;
  logic [ROW_W-1:0]  sweep_row;
  map_ent_t          map_cur;
  word_t             cache_cur;
  logic              cache_hit;
  logic              upd_vld;
  logic              new_to_cache;
  logic              new_to_bank;
  logic              old_to_bank;
  logic              old_clear;
  logic              bwr_en;
  logic [BANK_W-1:0] bwr_bank;
  word_t             bwr_data;

  // Map clear sweep, then ready one cycle later.
  always_ff @(posedge clk) begin
    if (rstvld) begin
      init_busy <= 1'b1;
      sweep_row <= '0;
      ready <= 1'b0;
    end else begin
      if (init_busy) begin
        sweep_row <= sweep_row + 1'b1;
        if (sweep_row == ROW_W'(NUM_ROWS - 1)) begin
          init_busy <= 1'b0;
        end
      end
      ready <= !init_busy;
    end
  end

  always_comb begin
    rd_acc.valid = rd.valid && ready;
    rd_acc.addr = rd.addr;
  end

  assign cache_rd_row = rd.addr.fld.row;

  // Memory outputs are stale by two cycles of writes.
  assign map_cur = pipe.map.vld ? pipe.map.ent : map_dout;
  assign cache_cur = pipe.cache.vld ? pipe.cache.data : cache_dout;
  assign cache_hit = map_cur.valid && (map_cur.bank == pipe.addr.fld.bank);

  always_comb begin
    rsp.valid = pipe.valid;
    if (pipe.data.vld) begin
      rsp.data = pipe.data.data;
    end else if (cache_hit) begin
      rsp.data = cache_cur;
    end else begin
      rsp.data = bank_dout[pipe.addr.fld.bank];
    end
  end

  // Update steering.
  assign upd_vld = upd.valid && pipe.valid;
  assign new_to_cache = upd_vld && rd_acc.valid &&
                        (rd_acc.addr.fld.bank == pipe.addr.fld.bank);
  assign new_to_bank = upd_vld && !new_to_cache;
  assign old_to_bank = new_to_cache && map_cur.valid &&
                       (map_cur.bank != pipe.addr.fld.bank);
  assign old_clear = new_to_bank && cache_hit;

  // Eviction shares the row of the update.
  assign bwr_en = new_to_bank || old_to_bank;
  assign bwr_bank = new_to_bank ? pipe.addr.fld.bank : map_cur.bank;
  assign bwr_data = new_to_bank ? upd.data : cache_cur;

  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_req[b].rd = rd_acc.valid && (rd_acc.addr.fld.bank == BANK_W'(b));
      bank_req[b].wr = bwr_en && (bwr_bank == BANK_W'(b));
      bank_req[b].row = bank_req[b].wr ? pipe.addr.fld.row : rd.addr.fld.row;
      bank_req[b].wdata = bwr_data;
    end
  end

  always_comb begin
    map_wr = '0;
    if (init_busy) begin
      map_wr.en = 1'b1;
      map_wr.row = sweep_row;
    end else if (new_to_cache) begin
      map_wr.en = 1'b1;
      map_wr.row = pipe.addr.fld.row;
      map_wr.ent.valid = 1'b1;
      map_wr.ent.bank = pipe.addr.fld.bank;
    end else if (old_clear) begin
      map_wr.en = 1'b1;
      map_wr.row = pipe.addr.fld.row;
    end
  end

  always_comb begin
    cache_wr.en = new_to_cache;
    cache_wr.row = pipe.addr.fld.row;
    cache_wr.data = upd.data;
  end

  always_comb begin
    upd_wr.en = bwr_en;
    upd_wr.addr.fld.row = pipe.addr.fld.row;
    upd_wr.addr.fld.bank = bwr_bank;
    upd_wr.data = bwr_data;
  end

endmodule

/* hdl/mem_1r1u_top.sv */
module mem_1r1u_top (
  input  logic                   clk,
  input  logic                   rstvld,
  input  mem_1r1u_pkg::rd_req_t  rd,
  input  mem_1r1u_pkg::upd_req_t upd,
  output mem_1r1u_pkg::rd_rsp_t  rsp,
  output logic                   ready
);
  import mem_1r1u_pkg::*;

  bank_req_t [NUM_BANKS-1:0] bank_req;
  word_t [NUM_BANKS-1:0]     bank_dout;
  map_wr_t                   map_wr;
  cache_wr_t                 cache_wr;
  logic [ROW_W-1:0]          rd_row;
  map_ent_t                  map_dout;
  word_t                     cache_dout;
  rd_req_t                   rd_acc;
  upd_wr_t                   upd_wr;
  pipe_out_t                 pipe;

  core_ctrl i_core_ctrl (
    .clk          (clk),
    .rstvld       (rstvld),
    .rd           (rd),
    .upd          (upd),
    .rsp          (rsp),
    .ready        (ready),
    .bank_req     (bank_req),
    .bank_dout    (bank_dout),
    .map_wr       (map_wr),
    .cache_wr     (cache_wr),
    .cache_rd_row (rd_row),
    .map_dout     (map_dout),
    .cache_dout   (cache_dout),
    .rd_acc       (rd_acc),
    .upd_wr       (upd_wr),
    .pipe         (pipe)
  );

  bank_array i_bank_array (
    .clk       (clk),
    .bank_req  (bank_req),
    .bank_dout (bank_dout)
  );

  dp_sram #(.WIDTH(DATA_W)) i_cache (
    .clk     (clk),
    .wr_en   (cache_wr.en),
    .wr_row  (cache_wr.row),
    .wr_data (cache_wr.data),
    .rd_row  (rd_row),
    .rd_data (cache_dout)
  );

  dp_sram #(.WIDTH($bits(map_ent_t))) i_map (
    .clk     (clk),
    .wr_en   (map_wr.en),
    .wr_row  (map_wr.row),
    .wr_data (map_wr.ent),
    .rd_row  (rd_row),
    .rd_data (map_dout)
  );

  rd_fwd_pipe i_rd_fwd_pipe (
    .clk      (clk),
    .rstvld   (rstvld),
    .rd_acc   (rd_acc),
    .map_wr   (map_wr),
    .cache_wr (cache_wr),
    .upd_wr   (upd_wr),
    .pipe     (pipe)
  );

endmodule

/* test/mem_1r1u_sva.sv */
module mem_1r1u_sva (
  input logic                                                 clk,
  input logic                                                 rstvld,
  input mem_1r1u_pkg::rd_req_t                                rd,
  input mem_1r1u_pkg::rd_rsp_t                                rsp,
  input logic                                                 ready,
  input mem_1r1u_pkg::bank_req_t [mem_1r1u_pkg::NUM_BANKS-1:0] bank_req
);
  import mem_1r1u_pkg::*;

  logic acc;

  assign acc = rd.valid && ready;

  // Fixed two cycle read latency.
  a_rsp_latency: assert property (@(posedge clk) disable iff (rstvld)
    rsp.valid == $past(acc, 2))
    else $error("rsp.valid not two cycles after an accepted read");

  a_ready_holds: assert property (@(posedge clk) disable iff (rstvld)
    ready |=> ready)
    else $error("ready fell after it was high");

  // Single-port banks.
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank_port
    a_one_op: assert property (@(posedge clk) disable iff (rstvld)
      !(bank_req[b].rd && bank_req[b].wr))
      else $error("bank %0d got a read and a write in one cycle", b);
  end

endmodule

bind mem_1r1u_top mem_1r1u_sva i_mem_1r1u_sva (
  .clk      (clk),
  .rstvld   (rstvld),
  .rd       (rd),
  .rsp      (rsp),
  .ready    (ready),
  .bank_req (bank_req)
);

/* test/tb_mem_1r1u.sv */
module tb_mem_1r1u;
  import mem_1r1u_pkg::*;

  localparam int RST_CYC = 16;
  localparam int PHASE_CYC = 500;
  // Init plus four phase budgets, with margin.
  localparam int TIMEOUT_CYC = RST_CYC + NUM_ROWS + 4 * PHASE_CYC + 1000;

  typedef struct packed {
    vaddr_u      addr;
    int unsigned due;
  } pend_t;

  logic        clk;
  logic        rstvld;
  rd_req_t     rd;
  upd_req_t    upd;
  rd_rsp_t     rsp;
  logic        ready;

  word_t       model_mem [1 << ADDR_W];
  logic        model_known [1 << ADDR_W];
  pend_t       pend_q [$];
  int unsigned cyc = 0;
  int unsigned rel_cyc;
  int          seed;
  int          err_cnt;
  int          check_cnt;
  int          pass_cnt;
  int          fail_cnt;

  mem_1r1u_top i_mem_1r1u_top (
    .clk    (clk),
    .rstvld (rstvld),
    .rd     (rd),
    .upd    (upd),
    .rsp    (rsp),
    .ready  (ready)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc == TIMEOUT_CYC) begin
      $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYC);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic ready_due();
    return cyc >= rel_cyc + NUM_ROWS + 1;
  endfunction

  task automatic check_ready(input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      $display("MISMATCH ready exp %h got %h at cycle %0d", exp, got, cyc);
      err_cnt++;
    end
  endtask

  task automatic check_rsp(input rd_rsp_t got, input rd_rsp_t exp, input logic known);
    check_cnt++;
    if (got.valid !== exp.valid) begin
      $display("MISMATCH rsp.valid exp %h got %h at cycle %0d", exp.valid, got.valid, cyc);
      err_cnt++;
    end else if (exp.valid && known && got.data !== exp.data) begin
      $display("MISMATCH rsp.data exp %h got %h at cycle %0d", exp.data, got.data, cyc);
      err_cnt++;
    end
  endtask

  // Called at the falling edge, when all outputs are settled.
  task automatic observe_cycle();
    rd_rsp_t exp;
    pend_t   p;
    logic    known;
    exp = '0;
    known = 1'b0;
    check_ready(ready, ready_due());
    if (pend_q.size() > 0 && pend_q[0].due == cyc) begin
      p = pend_q.pop_front();
      exp.valid = 1'b1;
      exp.data = model_mem[p.addr.flat];
      known = model_known[p.addr.flat];
      // The update lands after this response is formed.
      if (upd.valid) begin
        model_mem[p.addr.flat] = upd.data;
        model_known[p.addr.flat] = 1'b1;
      end
    end
    check_rsp(rsp, exp, known);
    if (rd.valid && ready_due()) begin
      pend_q.push_back('{addr: rd.addr, due: cyc + 2});
    end
  endtask

  task automatic run_cycle(input rd_req_t nxt_rd, input logic want_upd);
    upd_req_t nxt_upd;
    nxt_upd = '0;
    if (want_upd && pend_q.size() > 0 && pend_q[0].due == cyc + 1) begin
      nxt_upd.valid = 1'b1;
      nxt_upd.data = word_t'($random(seed));
    end
    @(posedge clk);
    rd <= nxt_rd;
    upd <= nxt_upd;
    @(negedge clk);
    observe_cycle();
  endtask

  task automatic finish_phase(input string name, input int err_mark);
    for (int i = 0; i <= SRAM_DELAY; i++) begin
      run_cycle('0, 1'b0);
    end
    if (err_cnt == err_mark) begin
      $display("PASS %s", name);
      pass_cnt++;
    end else begin
      $display("FAIL %s with %0d errors", name, err_cnt - err_mark);
      fail_cnt++;
    end
  endtask

  // Reads during the sweep must be dropped.
  task automatic run_init();
    rd_req_t r;
    int      err_mark;
    err_mark = err_cnt;
    for (int i = 0; i < NUM_ROWS + 4; i++) begin
      r.valid = ($random(seed) & 1) != 0;
      r.addr.flat = ADDR_W'($random(seed));
      run_cycle(r, 1'b0);
    end
    if (ready !== 1'b1) begin
      $display("ready did not rise after the map clear sweep");
      err_cnt++;
    end
    finish_phase("init", err_mark);
  endtask

  task automatic run_random(input int n);
    rd_req_t r;
    int      err_mark;
    err_mark = err_cnt;
    for (int i = 0; i < n; i++) begin
      r.valid = ($random(seed) & 3) != 0;
      r.addr.flat = ADDR_W'($random(seed));
      run_cycle(r, ($random(seed) & 1) != 0);
    end
    finish_phase("random", err_mark);
  endtask

  // Back-to-back reads to one bank, moving to the next bank every 40 cycles.
  task automatic run_pressure(input int n);
    rd_req_t r;
    int      err_mark;
    err_mark = err_cnt;
    for (int i = 0; i < n; i++) begin
      r.valid = 1'b1;
      r.addr.fld.row = ROW_W'($random(seed));
      r.addr.fld.bank = BANK_W'(i / 40);
      run_cycle(r, 1'b1);
    end
    finish_phase("bank_pressure", err_mark);
  endtask

  // Four addresses, so most reads overlap an update in flight.
  task automatic run_hazard(input int n);
    rd_req_t r;
    int      err_mark;
    err_mark = err_cnt;
    for (int i = 0; i < n; i++) begin
      r.valid = ($random(seed) & 7) != 0;
      r.addr.fld.row = ROW_W'($random(seed) & 1);
      r.addr.fld.bank = BANK_W'($random(seed) & 1);
      run_cycle(r, 1'b1);
    end
    finish_phase("hazard", err_mark);
  endtask

  task automatic run_sweep();
    rd_req_t r;
    int      err_mark;
    err_mark = err_cnt;
    for (int a = 0; a < (1 << ADDR_W); a++) begin
      r.valid = 1'b1;
      r.addr.flat = ADDR_W'(a);
      run_cycle(r, 1'b0);
    end
    finish_phase("final_sweep", err_mark);
  endtask

  initial begin
    clk = 1'b0;
    rstvld = 1'b1;
    rd = '0;
    upd = '0;
    seed = 11;
    err_cnt = 0;
    check_cnt = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    for (int a = 0; a < (1 << ADDR_W); a++) begin
      model_known[a] = 1'b0;
    end
    repeat (RST_CYC) @(posedge clk);
    rstvld <= 1'b0;
    @(negedge clk);
    rel_cyc = cyc;
    observe_cycle();
    run_init();
    run_random(PHASE_CYC);
    run_pressure(PHASE_CYC);
    run_hazard(PHASE_CYC);
    run_sweep();
    if (pend_q.size() != 0) begin
      $display("%0d reads never got a response", pend_q.size());
      err_cnt++;
    end
    $display("Summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
             pass_cnt, fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* list.f */
hdl/mem_1r1u_pkg.sv
hdl/dp_sram.sv
hdl/bank_array.sv
hdl/rd_fwd_pipe.sv
hdl/core_ctrl.sv
hdl/mem_1r1u_top.sv
test/mem_1r1u_sva.sv
test/tb_mem_1r1u.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_1r1u
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Regression passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
